// File: dv/ahb_uart_assert.sv
`timescale 1ns/1ps

module ahb_uart_assert (
  input logic                   HCLK,
  input logic                   HRESETn,
  input logic                   HREADYOUT,
  input logic                   HRESP,
  input logic                   TX_OUT,
  input uart_pkg::fifo_status_t tx_status,
  input uart_pkg::fifo_status_t rx_status,
  input uart_pkg::tx_state_e    tx_state
);
  import uart_pkg::*;

  // zero wait states, OKAY only
  bus_resp_ok: assert property (@(posedge HCLK) disable iff (!HRESETn)
    HREADYOUT && !HRESP)
    else $error("bus response is not ready with OKAY");

  tx_flags_ok: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(tx_status.full && tx_status.empty))
    else $error("TX FIFO shows full and empty together");

  rx_flags_ok: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(rx_status.full && rx_status.empty))
    else $error("RX FIFO shows full and empty together");

  // idle engine keeps the line at mark
  tx_idle_mark: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (tx_state == TX_IDLE) |-> TX_OUT)
    else $error("TX_OUT low while the TX engine is idle");

endmodule

bind ahb_uart ahb_uart_assert i_ahb_uart_assert (
  .HCLK, .HRESETn, .HREADYOUT, .HRESP, .TX_OUT, .tx_status, .rx_status,
  .tx_state(i_uart_tx.state)
);

// File: dv/tb_ahb_uart.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_ahb_uart;
  import uart_pkg::*;

  localparam int TX_BYTES  = 8;
  localparam int RX_BYTES  = 6;
  localparam int OVF_BYTES = 18;
  // worst-case frame cycles at 20 half bits of (div+1)
  localparam int FRAME_SUM   = 20 * (TX_BYTES * 4 + RX_BYTES * 7 + (OVF_BYTES - 1) * 4 + 4);
  localparam int CYCLE_LIMIT = FRAME_SUM * 3 / 2;

  logic        HCLK, HRESETn, HSEL, HWRITE, HREADY, HREADYOUT, HRESP;
  logic [15:0] HADDR;
  logic [1:0]  HTRANS;
  logic [2:0]  HSIZE;
  logic [31:0] HWDATA, HRDATA;
  logic        TX_OUT, RX_IN;

  logic        m_en;
  logic [15:0] m_div;
  logic [7:0]  tx_exp[$];
  logic [7:0]  tx_got[$];
  logic [7:0]  rx_exp[$];
  logic [7:0]  tx_fifo_m[$];
  string       cur_test;
  int          errs, tests_run, tests_failed, cycle_cnt;

  ahb_uart i_ahb_uart (
    .HCLK, .HRESETn, .HSEL, .HADDR, .HTRANS, .HSIZE, .HWRITE, .HWDATA, .HREADY,
    .HREADYOUT, .HRDATA, .HRESP, .TX_OUT, .RX_IN
  );

  always #5 HCLK = ~HCLK;

  always @(posedge HCLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("run stopped after %0d cycles, stuck in %s", cycle_cnt, cur_test);
      $display("Test FAILED");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // checking and reporting
  // ---------------------------------------------------------------------------
  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("Fail %s (%s): expected %h actual %h", cur_test, what, exp, act);
      errs++;
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (errs == 0)
      $display("%s: passed", cur_test);
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, errs);
    end
    errs = 0;
  endtask

  function automatic logic [7:0] status_byte(logic en, logic txf, logic txe, logic rxf,
                                             logic rxe);
    logic [7:0] s;
    s                = '0;
    s[`UART_ST_EN]   = en;
    s[`UART_ST_TXF]  = txf;
    s[`UART_ST_TXE]  = txe;
    s[`UART_ST_RXF]  = rxf;
    s[`UART_ST_RXE]  = rxe;
    return s;
  endfunction

  // ---------------------------------------------------------------------------
  // AHB transfers with one address phase and one data phase
  // ---------------------------------------------------------------------------
  task automatic ahb_write(input logic [15:0] addr, input logic [2:0] size,
                           input logic [31:0] data);
    @(posedge HCLK);
    #1;
    HSEL   = 1'b1;
    HADDR  = addr;
    HTRANS = 2'b10;   // NONSEQ
    HSIZE  = size;
    HWRITE = 1'b1;
    @(posedge HCLK);
    #1;
    HSEL   = 1'b0;
    HTRANS = 2'b00;
    HWRITE = 1'b0;
    HWDATA = data;
  endtask

  task automatic ahb_read(input logic [15:0] addr, input logic [2:0] size,
                          output logic [31:0] data);
    @(posedge HCLK);
    #1;
    HSEL   = 1'b1;
    HADDR  = addr;
    HTRANS = 2'b10;
    HSIZE  = size;
    HWRITE = 1'b0;
    @(posedge HCLK);
    #1;
    HSEL   = 1'b0;
    HTRANS = 2'b00;
    data   = HRDATA;   // data phase, combinational
  endtask

  task automatic set_divisor(input logic [15:0] div);
    m_div = div;
    ahb_write(16'h0002, SIZE_HALF, {div, 16'($urandom)});   // low lanes ignored
  endtask

  task automatic wait_rx_ready();
    logic [31:0] d;
    ahb_read(16'h0000, SIZE_BYTE, d);
    while (d[`UART_ST_RXE])
      ahb_read(16'h0000, SIZE_BYTE, d);
  endtask

  // ---------------------------------------------------------------------------
  // serial model for 8N1 at 2*(div+1) cycles per bit
  // ---------------------------------------------------------------------------
  task automatic send_frame(input logic [7:0] b);
    logic [9:0] frame;
    int         bit_cyc;
    frame   = {1'b1, b, 1'b0};
    bit_cyc = 2 * (int'(m_div) + 1);
    for (int i = 0; i < 10; i++)
    begin
      @(posedge HCLK);
      #1;
      RX_IN = frame[i];
      repeat (bit_cyc - 1) @(posedge HCLK);
    end
  endtask

  task automatic decode_frame();
    logic [7:0] b;
    int         bit_cyc;
    bit_cyc = 2 * (int'(m_div) + 1);
    repeat (bit_cyc / 2) @(negedge HCLK);   // middle of start bit
    for (int i = 0; i < 8; i++)
    begin
      repeat (bit_cyc) @(negedge HCLK);
      b[i] = TX_OUT;
    end
    repeat (bit_cyc) @(negedge HCLK);
    assert (TX_OUT === 1'b1)
    else
    begin
      $display("%s: TX_OUT frame has no stop bit", cur_test);
      errs++;
    end
    tx_got.push_back(b);
  endtask

  always @(negedge HCLK)
  begin
    if (HRESETn === 1'b1 && TX_OUT === 1'b0)
      decode_frame();
  end

  task automatic compare_tx_stream();
    while (tx_got.size() < tx_exp.size())
      @(negedge HCLK);
    foreach (tx_exp[i])
      check_eq("tx byte", 32'(tx_exp[i]), 32'(tx_got[i]));
    // room for one more frame to show up
    repeat ((`UART_TX_TICKS + 4) * (int'(m_div) + 1)) @(negedge HCLK);
    check_eq("tx byte count", 32'(tx_exp.size()), 32'(tx_got.size()));
    tx_exp.delete();
    tx_got.delete();
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------
  initial
  begin
    logic [31:0] d;
    logic [13:0] w;
    logic [7:0]  b;
    logic        busy, low_seen;
    HCLK = 1'b0;
    HRESETn = 1'b0;
    HSEL = 1'b0;
    HADDR = '0;
    HTRANS = 2'b00;
    HSIZE = 3'b000;
    HWRITE = 1'b0;
    HWDATA = '0;
    HREADY = 1'b1;
    RX_IN = 1'b1;
    m_en = 1'b0;
    m_div = '0;
    errs = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_cnt = 0;
    cur_test = "reset";
    void'($urandom(32'h5c6e_23bc));
    repeat (8) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;

    cur_test = "reset_values";
    ahb_read(16'h0000, SIZE_WORD, d);
    check_eq("word 0", {24'h0, status_byte(1'b0, 1'b0, 1'b1, 1'b0, 1'b1)}, d);
    check_eq("tx line", 32'd1, 32'(TX_OUT));
    finish_test();

    cur_test = "byte_strobes";
    set_divisor(16'($urandom));
    m_en = 1'b1;
    ahb_write(16'h0000, SIZE_BYTE, {$urandom} | 32'h1);   // only lane 0 taken
    ahb_read(16'h0000, SIZE_WORD, d);
    check_eq("word 0", {m_div, 8'h00, status_byte(m_en, 1'b0, 1'b1, 1'b0, 1'b1)}, d);
    b = 8'($urandom);
    m_div[15:8] = b;
    ahb_write(16'h0003, SIZE_BYTE, {b, 24'($urandom)});
    ahb_read(16'h0000, SIZE_WORD, d);
    check_eq("upper divisor byte", {m_div, 8'h00, status_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1)},
             d);
    w = 14'($urandom_range(1, 16383));
    ahb_read({w, 2'b00}, SIZE_WORD, d);
    check_eq("other word", 32'h0, d);
    finish_test();

    cur_test = "tx_frames";
    set_divisor(16'($urandom_range(1, 3)));
    for (int i = 0; i < TX_BYTES; i++)
    begin
      b = 8'($urandom);
      tx_exp.push_back(b);
      ahb_write(16'h0001, SIZE_BYTE, {16'($urandom), b, 8'h00});
    end
    compare_tx_stream();
    finish_test();

    cur_test = "rx_frames";
    set_divisor(16'($urandom_range(3, 6)));
    for (int i = 0; i < RX_BYTES; i++)
    begin
      b = 8'($urandom);
      rx_exp.push_back(b);
      send_frame(b);
      wait_rx_ready();
      ahb_read(16'h0001, SIZE_BYTE, d);
      check_eq("rx byte", 32'(rx_exp.pop_front()), 32'(d[15:8]));
    end
    ahb_read(16'h0000, SIZE_BYTE, d);
    check_eq("rx empty", 32'd1, 32'(d[`UART_ST_RXE]));
    finish_test();

    cur_test = "tx_overflow";
    set_divisor(16'd3);
    busy = 1'b0;
    for (int i = 0; i < OVF_BYTES; i++)
    begin
      b = 8'($urandom);
      if (!busy)
      begin
        busy = 1'b1;   // first byte goes straight to the shifter
        tx_exp.push_back(b);
      end
      else if (tx_fifo_m.size() < `UART_FIFO_DEPTH)
      begin
        tx_fifo_m.push_back(b);
        tx_exp.push_back(b);
      end
      ahb_write(16'h0001, SIZE_BYTE, {16'h0, b, 8'h00});
    end
    ahb_read(16'h0000, SIZE_BYTE, d);
    check_eq("tx full", 32'(tx_fifo_m.size() == `UART_FIFO_DEPTH), 32'(d[`UART_ST_TXF]));
    tx_fifo_m.delete();
    compare_tx_stream();
    finish_test();

    cur_test = "disable_flush";
    b = 8'($urandom);
    rx_exp.push_back(b);
    send_frame(b);
    wait_rx_ready();
    ahb_write(16'h0000, SIZE_BYTE, 32'h0);
    m_en = 1'b0;
    rx_exp.delete();
    ahb_read(16'h0000, SIZE_WORD, d);
    check_eq("word 0",
             {m_div, 8'h00, status_byte(m_en, 1'b0, 1'b1, 1'b0, rx_exp.size() == 0)}, d);
    low_seen = 1'b0;
    repeat (4 * (int'(m_div) + 1))
    begin
      @(negedge HCLK);
      if (TX_OUT !== 1'b1)
        low_seen = 1'b1;
    end
    check_eq("tx line low", 32'd0, 32'(low_seen));
    finish_test();

    $display("%0d tests, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: include/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// ---------------------------------------------------------------------------
// widths and sizes
// ---------------------------------------------------------------------------
`define UART_DATA_W        8
`define UART_DIV_W         16
`define UART_FIFO_DEPTH    16
`define UART_FIFO_AW       4
`define UART_ADDR_W        16

`define UART_REG_WORD      0    // only decoded word

// half-bit tick counts
`define UART_TX_TICKS      20
`define UART_RX_LAST_TICK  18
`define UART_SAMPLES       6    // voter history depth

// status byte layout
`define UART_ST_EN         0
`define UART_ST_TXF        1
`define UART_ST_TXE        2
`define UART_ST_RXF        3
`define UART_ST_RXE        4

`endif

// File: rtl/ahb_slave_if.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module ahb_slave_if (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic                    HSEL,
  input  logic [`UART_ADDR_W-1:0] HADDR,
  input  logic [1:0]              HTRANS,
  input  uart_pkg::hsize_e        HSIZE,
  input  logic                    HWRITE,
  input  logic                    HREADY,
  output uart_pkg::reg_access_t   acc
);
  import uart_pkg::*;

  logic       req;
  logic [3:0] strb_nxt;

  // NONSEQ or SEQ to this slave, previous transfer done
  assign req = HREADY & HSEL & HTRANS[1];

  // byte lanes from size and low address bits
  always_comb
  begin
    case (HSIZE)
      SIZE_BYTE: strb_nxt = 4'b0001 << HADDR[1:0];
      SIZE_HALF: strb_nxt = HADDR[1] ? 4'b1100 : 4'b0011;
      default:   strb_nxt = 4'b1111;
    endcase
  end

  // ---------------------------------------------------------------------------
  // address phase -> data phase
  // ---------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      acc <= '0;
    end
    else if (req)
    begin
      acc.word <= HADDR[`UART_ADDR_W-1:2];
      acc.strb <= strb_nxt;
      acc.rd   <= ~HWRITE;
      acc.wr   <= HWRITE;
    end
    else if (HREADY)
    begin
      acc.rd <= 1'b0;   // transfer finished, nothing new
      acc.wr <= 1'b0;
    end
  end

endmodule

// File: rtl/ahb_uart.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module ahb_uart (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic                    HSEL,
  input  logic [`UART_ADDR_W-1:0] HADDR,
  input  logic [1:0]              HTRANS,
  input  logic [2:0]              HSIZE,
  input  logic                    HWRITE,
  input  logic [31:0]             HWDATA,
  input  logic                    HREADY,
  output logic                    HREADYOUT,
  output logic [31:0]             HRDATA,
  output logic                    HRESP,
  output logic                    TX_OUT,
  input  logic                    RX_IN
);
  import uart_pkg::*;

  hsize_e                   hsize;
  reg_access_t              acc;
  logic                     en;
  logic                     flush;
  logic [`UART_DIV_W-1:0]   baud_div;
  logic                     tx_push, tx_pop;
  logic [`UART_DATA_W-1:0]  tx_wdata, tx_rdata;
  fifo_status_t             tx_status;
  logic                     rx_push, rx_pop;
  logic [`UART_DATA_W-1:0]  rx_wdata, rx_rdata;
  fifo_status_t             rx_status;

  assign HREADYOUT = 1'b1;   // zero wait states
  assign HRESP     = 1'b0;   // always OKAY
  assign hsize     = hsize_e'(HSIZE);

  ahb_slave_if i_ahb_slave_if (
    .HCLK, .HRESETn, .HSEL, .HADDR, .HTRANS, .HSIZE(hsize), .HWRITE, .HREADY, .acc
  );

  uart_regs i_uart_regs (
    .HCLK, .HRESETn, .acc, .HWDATA, .tx_status, .rx_status, .rx_rdata,
    .HRDATA, .en, .baud_div, .flush, .tx_push, .tx_wdata, .rx_pop
  );

  uart_fifo tx_fifo (
    .HCLK, .HRESETn, .flush, .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
    .rdata(tx_rdata), .status(tx_status)
  );

  uart_fifo rx_fifo (
    .HCLK, .HRESETn, .flush, .push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
    .rdata(rx_rdata), .status(rx_status)
  );

  uart_tx i_uart_tx (
    .HCLK, .HRESETn, .en, .baud_div, .tx_rdata, .tx_status, .tx_pop, .TX_OUT
  );

  uart_rx i_uart_rx (
    .HCLK, .HRESETn, .en, .baud_div, .RX_IN, .rx_status, .rx_push, .rx_wdata
  );

endmodule

// File: rtl/baud_tick.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module baud_tick (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   run,
  input  logic [`UART_DIV_W-1:0] baud_div,
  output logic                   tick
);

  logic [`UART_DIV_W-1:0] cnt;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      cnt  <= '0;
      tick <= 1'b0;
    end
    else if (!run)
    begin
      cnt  <= '0;   // restart phase for next frame
      tick <= 1'b0;
    end
    else if (cnt == baud_div)
    begin
      cnt  <= '0;
      tick <= 1'b1;
    end
    else
    begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

// File: rtl/uart_fifo.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_fifo #(
  parameter int DEPTH_LOG2 = `UART_FIFO_AW
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     flush,
  input  logic                     push,
  input  logic [`UART_DATA_W-1:0]  wdata,
  input  logic                     pop,
  output logic [`UART_DATA_W-1:0]  rdata,
  output uart_pkg::fifo_status_t   status
);

  logic [`UART_DATA_W-1:0] mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2:0]     wr_ptr, rd_ptr;   // msb is the wrap bit
  logic                    do_push, do_pop;

  assign status.full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                        (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);
  assign status.empty = (wr_ptr == rd_ptr);

  assign do_push = push & ~status.full;
  assign do_pop  = pop & ~status.empty;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else if (flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (do_push)
      mem[wr_ptr[DEPTH_LOG2-1:0]] <= wdata;
  end

  assign rdata = mem[rd_ptr[DEPTH_LOG2-1:0]];   // head, valid when not empty

endmodule

// File: rtl/uart_pkg.sv
`include "uart_consts.svh"

package uart_pkg;

  // AHB HSIZE encodings used by the slave
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010
  } hsize_e;

  // data-phase view of one register access
  typedef struct packed {
    logic                      rd;
    logic                      wr;
    logic [3:0]                strb;
    logic [`UART_ADDR_W-3:0]   word;   // HADDR[15:2]
  } reg_access_t;

  typedef struct packed {
    logic full;
    logic empty;
  } fifo_status_t;

  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;
  typedef enum logic {RX_IDLE, RX_RECV} rx_state_e;

endpackage

// File: rtl/uart_regs.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_regs (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  uart_pkg::reg_access_t    acc,
  input  logic [31:0]              HWDATA,
  input  uart_pkg::fifo_status_t   tx_status,
  input  uart_pkg::fifo_status_t   rx_status,
  input  logic [`UART_DATA_W-1:0]  rx_rdata,
  output logic [31:0]              HRDATA,
  output logic                     en,
  output logic [`UART_DIV_W-1:0]   baud_div,
  output logic                     flush,
  output logic                     tx_push,
  output logic [`UART_DATA_W-1:0]  tx_wdata,
  output logic                     rx_pop
);

  localparam logic [`UART_ADDR_W-3:0] REG_WORD = `UART_REG_WORD;

  logic                    hit;
  logic                    wr_hit;
  logic                    rd_hit;
  logic [7:0]              status;
  logic [`UART_DATA_W-1:0] rx_byte;

  assign hit    = (acc.word == REG_WORD);
  assign wr_hit = acc.wr & hit;
  assign rd_hit = acc.rd & hit;

  // ---------------------------------------------------------------------------
  // enable and divisor
  // ---------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      en       <= 1'b0;
      baud_div <= '0;
    end
    else if (wr_hit)
    begin
      if (acc.strb[0])
        en <= HWDATA[`UART_ST_EN];
      if (acc.strb[2])
        baud_div[7:0] <= HWDATA[23:16];
      if (acc.strb[3])
        baud_div[15:8] <= HWDATA[31:24];
    end
  end

  assign flush = ~en;   // disabled uart holds both FIFOs empty

  // data lane pushes TX, pops RX; full/empty drop the request
  assign tx_push  = wr_hit & acc.strb[1] & ~tx_status.full;
  assign tx_wdata = HWDATA[15:8];
  assign rx_pop   = rd_hit & acc.strb[1] & ~rx_status.empty;

  always_comb
  begin
    status                = '0;
    status[`UART_ST_EN]   = en;
    status[`UART_ST_TXF]  = tx_status.full;
    status[`UART_ST_TXE]  = tx_status.empty;
    status[`UART_ST_RXF]  = rx_status.full;
    status[`UART_ST_RXE]  = rx_status.empty;
  end

  assign rx_byte = rx_status.empty ? '0 : rx_rdata;   // stale entry hidden
  assign HRDATA  = rd_hit ? {baud_div, rx_byte, status} : '0;

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     en,
  input  logic [`UART_DIV_W-1:0]   baud_div,
  input  logic                     RX_IN,
  input  uart_pkg::fifo_status_t   rx_status,
  output logic                     rx_push,
  output logic [`UART_DATA_W-1:0]  rx_wdata
);
  import uart_pkg::*;

  localparam int CNT_W  = $clog2(`UART_RX_LAST_TICK + 1);
  localparam int ONES_W = $clog2(`UART_SAMPLES + 1);
  localparam int HALF   = `UART_SAMPLES / 2;
  localparam int SH_W   = `UART_DATA_W + 1;   // start bit plus data

  rx_state_e                state;
  logic [`UART_SAMPLES-1:0] samp;
  logic [ONES_W-1:0]        ones;
  logic                     vote_low, vote_high, vote_low_d;
  logic                     start;
  logic [SH_W-1:0]          shreg;
  logic [CNT_W-1:0]         cnt;
  logic                     tick;
  logic                     last;
  logic                     sample;

  baud_tick i_baud_tick (
    .HCLK, .HRESETn, .run(state == RX_RECV), .baud_div, .tick
  );

  // ---------------------------------------------------------------------------
  // sample history and majority vote
  // ---------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      samp       <= '1;   // idle line
      vote_low_d <= 1'b0;
    end
    else
    begin
      samp       <= {RX_IN, samp[`UART_SAMPLES-1:1]};
      vote_low_d <= vote_low;
    end
  end

  assign ones      = ONES_W'($countones(samp));
  assign vote_low  = ones < HALF;
  assign vote_high = ones > HALF;   // exact split is undecided

  assign start  = en & (state == RX_IDLE) & vote_low & ~vote_low_d;
  assign last   = (cnt == CNT_W'(`UART_RX_LAST_TICK));
  assign sample = (state == RX_RECV) & tick & ~cnt[0] & ~last;

  // ---------------------------------------------------------------------------
  // frame control
  // ---------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state <= RX_IDLE;
      cnt   <= '0;
    end
    else if (!en)
    begin
      state <= RX_IDLE;
      cnt   <= '0;
    end
    else if (start)
    begin
      state <= RX_RECV;
      cnt   <= '0;
    end
    else if (state == RX_RECV && tick)
    begin
      if (last)
      begin
        state <= RX_IDLE;   // ends early, stop bit not sampled
        cnt   <= '0;
      end
      else
        cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (sample)
    begin
      if (vote_high)
        shreg <= {1'b1, shreg[SH_W-1:1]};
      else if (vote_low)
        shreg <= {1'b0, shreg[SH_W-1:1]};
      else
        shreg <= {~shreg[SH_W-1], shreg[SH_W-1:1]};   // slow edge, guess a flip
    end
  end

  assign rx_push  = en & (state == RX_RECV) & tick & last & ~rx_status.full;
  assign rx_wdata = shreg[SH_W-1:1];

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     en,
  input  logic [`UART_DIV_W-1:0]   baud_div,
  input  logic [`UART_DATA_W-1:0]  tx_rdata,
  input  uart_pkg::fifo_status_t   tx_status,
  output logic                     tx_pop,
  output logic                     TX_OUT
);
  import uart_pkg::*;

  localparam int CNT_W = $clog2(`UART_TX_TICKS);
  localparam int SH_W  = `UART_DATA_W + 3;   // start, data, two stop

  tx_state_e        state;
  logic [SH_W-1:0]  shreg;
  logic [CNT_W-1:0] cnt;
  logic             tick;

  baud_tick i_baud_tick (
    .HCLK, .HRESETn, .run(state == TX_SHIFT), .baud_div, .tick
  );

  // load a frame straight from the FIFO head
  assign tx_pop = en & (state == TX_IDLE) & ~tx_status.empty;
  assign TX_OUT = shreg[0];

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state <= TX_IDLE;
      shreg <= '1;
      cnt   <= '0;
    end
    else if (!en)
    begin
      state <= TX_IDLE;   // line back to mark
      shreg <= '1;
      cnt   <= '0;
    end
    else if (tx_pop)
    begin
      state <= TX_SHIFT;
      shreg <= {2'b11, tx_rdata, 1'b0};
      cnt   <= '0;
    end
    else if (state == TX_SHIFT && tick)
    begin
      if (cnt == CNT_W'(`UART_TX_TICKS - 1))
      begin
        state <= TX_IDLE;
        shreg <= '1;
        cnt   <= '0;
      end
      else
      begin
        if (cnt[0])
          shreg <= {1'b1, shreg[SH_W-1:1]};   // next bit every second tick
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_ahb_uart -o sim_tb_ahb_uart
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_ahb_uart)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// File: sim.f
+incdir+include
rtl/uart_pkg.sv
rtl/ahb_slave_if.sv
rtl/uart_regs.sv
rtl/uart_fifo.sv
rtl/baud_tick.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/ahb_uart.sv
dv/ahb_uart_assert.sv
dv/tb_ahb_uart.sv
